//--- hdl/otp_cfg.svh
/*
  Sizes and timing shared by the OTP life cycle interface and the macro model.
  Include this header in any module that needs word widths, counts or latency.
*/
`ifndef OTP_CFG_SVH
`define OTP_CFG_SVH

// Native OTP word width in bits
`define OTP_WIDTH 16

// Native words that make up the life cycle state vector
`define LC_WORDS 8

// Width of the full life cycle vector
`define LC_DATA_WIDTH (`OTP_WIDTH * `LC_WORDS)

// Width of the word counter
`define LC_CNT_WIDTH $clog2(`LC_WORDS)

// Word address width, the array holds 2**6 words
`define OTP_ADDR_WIDTH 6

// Word address of the first life cycle word
`define LC_OFFSET 40

// Cycles from grant to response valid
`define MACRO_LATENCY 2

`endif

//--- hdl/otp_macro_pkg.sv
/*
  Command and error codes of the OTP macro port.
  Shared by the life cycle interface, the macro model and the testbench.
*/
package otp_macro_pkg;

  ////////////////////////////////////////
  // Macro commands
  ////////////////////////////////////////

  // One bit is enough, only read and program exist
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } cmd_e;

  ////////////////////////////////////////
  // Error codes
  ////////////////////////////////////////

  // Reported by the macro with each response
  // and latched by the interface as its own error state
  typedef enum logic [1:0] {
    // Operation completed cleanly
    NoError              = 2'd0,
    // Write tried to clear an already programmed bit
    MacroWriteBlankError = 2'd1,
    // FSM glitch, escalation or counter mismatch
    FsmStateError        = 2'd2
  } err_e;

  // Value 2'd3 is not used and reads as an error
  // if it ever shows up on a port

endpackage

//--- hdl/lc_tx_pkg.sv
/*
  Multi-bit life cycle signal type with its On and Off values.
  Consumers decode it with the loose test so any corruption counts as On.
*/
package lc_tx_pkg;

  // Four bits so a single flipped bit cannot turn Off into On
  typedef logic [3:0] lc_tx_t;

  // Complementary patterns that sit far apart in Hamming distance
  localparam lc_tx_t LcTxOn  = 4'b0101;
  localparam lc_tx_t LcTxOff = 4'b1010;

  ////////////////////////////////////////
  // Decoding
  ////////////////////////////////////////

  // Anything except the exact Off pattern decodes as true
  // Used where a false positive is the safe direction
  function automatic logic lc_tx_test_true_loose(lc_tx_t val);
    logic is_true;
    is_true = (val != LcTxOff);
    return is_true;
  endfunction

endpackage

//--- hdl/lci_word_count.sv
/*
  Redundant word counter for the life cycle interface.
  An up count and a down shadow move together and flag any disagreement.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module lci_word_count (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Restart from word zero
  input  logic                       clr_i,
  // Advance to the next word
  input  logic                       incr_i,
  output logic [`LC_CNT_WIDTH-1:0]   cnt_o,
  // High while the two counters disagree
  output logic                       err_o
);

  localparam int CntWidth = `LC_CNT_WIDTH;

  logic [CntWidth-1:0] up_q;
  logic [CntWidth-1:0] dn_q;
  logic [CntWidth-1:0] sum;

  ////////////////////////////////////////
  // Counter pair
  ////////////////////////////////////////

  // Up count starts at zero, the shadow at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (clr_i) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (incr_i) begin
      up_q <= up_q + CntWidth'(1);
      dn_q <= dn_q - CntWidth'(1);
    end
  end

  ////////////////////////////////////////
  // Consistency check
  ////////////////////////////////////////

  // Up plus down always wraps to all ones
  // A glitch on either register breaks the sum
  assign sum   = up_q + dn_q;
  assign err_o = (sum != {CntWidth{1'b1}});

  // Only the up count drives the address
  assign cnt_o = up_q;

endmodule

//--- hdl/otp_lci.sv
/*
  Life cycle interface of the OTP controller.
  Burns the life cycle vector word by word and locks up on any fault.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module otp_lci (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        lci_en_i,
  // Multi-bit escalation, forces the terminal state
  input  lc_tx_pkg::lc_tx_t           escalate_en_i,
  // Level request and full vector from the life cycle controller
  input  logic                        lc_req_i,
  input  logic [`LC_DATA_WIDTH-1:0]   lc_data_i,
  output logic                        lc_ack_o,
  output logic                        lc_err_o,
  output otp_macro_pkg::err_e         error_o,
  output logic                        fsm_err_o,
  output logic                        lci_prog_idle_o,
  // Macro request side
  output logic                        otp_req_o,
  output otp_macro_pkg::cmd_e         otp_cmd_o,
  output logic [`OTP_ADDR_WIDTH-1:0]  otp_addr_o,
  output logic [`OTP_WIDTH-1:0]       otp_wdata_o,
  // Macro response side
  input  logic                        otp_gnt_i,
  input  logic                        otp_rvalid_i,
  input  otp_macro_pkg::err_e         otp_err_i
);

  import otp_macro_pkg::*;
  import lc_tx_pkg::*;

  localparam int CntWidth = `LC_CNT_WIDTH;
  localparam logic [CntWidth-1:0] LastWord = CntWidth'(`LC_WORDS - 1);
  localparam logic [`OTP_ADDR_WIDTH-1:0] LcBase = `OTP_ADDR_WIDTH'(`LC_OFFSET);

  // Sparse encoding, minimum Hamming distance 5 between states
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } state_e;

  state_e state_d, state_q;
  err_e error_d, error_q;
  logic cnt_clr, cnt_incr, cnt_err;
  logic [CntWidth-1:0] cnt;
  logic [`LC_WORDS-1:0][`OTP_WIDTH-1:0] lc_words;

  ////////////////////////////////////////
  // Programming FSM
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    lci_prog_idle_o = 1'b1;
    otp_req_o       = 1'b0;
    otp_cmd_o       = Read;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;

    case (state_q)
      // Hold off until the interface is enabled
      ResetSt: begin
        lci_prog_idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Wait for a transition request, start from word zero
      IdleSt: begin
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Request held until the macro grants it
      WriteSt: begin
        lci_prog_idle_o = 1'b0;
        otp_req_o       = 1'b1;
        otp_cmd_o       = Write;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      // Wait for the response of the current word
      WriteWaitSt: begin
        lci_prog_idle_o = 1'b0;
        if (otp_rvalid_i) begin
          // Keep the error code but carry on with the remaining words
          if (otp_err_i != NoError) begin
            error_d = otp_err_i;
          end
          if (cnt == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failed word makes the whole transition fail
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_incr = 1'b1;
            state_d  = WriteSt;
          end
        end
      end
      // Terminal state, never left until reset
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation or counter mismatch overrides whatever the FSM decided
    if (lc_tx_test_true_loose(escalate_en_i) || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  assign error_o = error_q;

  ////////////////////////////////////////
  // Word counter and data path
  ////////////////////////////////////////

  lci_word_count u_word_count (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Word address inside the life cycle partition
  assign otp_addr_o = LcBase + `OTP_ADDR_WIDTH'(cnt);

  // Current slice of the vector, zero when not requesting
  assign lc_words    = lc_data_i;
  assign otp_wdata_o = otp_req_o ? lc_words[cnt] : '0;

endmodule

//--- hdl/otp_macro_model.sv
/*
  Behavioral single-port OTP macro with fixed response latency.
  Writes can only set bits, clearing a programmed bit reports an error.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module otp_macro_model (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  otp_macro_pkg::cmd_e         cmd_i,
  input  logic [`OTP_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`OTP_WIDTH-1:0]       wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output otp_macro_pkg::err_e         err_o
);

  import otp_macro_pkg::*;

  localparam int Depth   = 1 << `OTP_ADDR_WIDTH;
  localparam int Latency = `MACRO_LATENCY;

  logic [`OTP_WIDTH-1:0] mem_q [Depth];
  logic [Latency-1:0]    vld_q;
  err_e                  err_q [Latency];
  logic                  busy;
  logic                  blank_err;
  err_e                  rsp_err;

  ////////////////////////////////////////
  // Grant and blank check
  ////////////////////////////////////////

  // One operation in flight at a time
  assign busy  = |vld_q;
  assign gnt_o = req_i & ~busy;

  // Old ones where the new word has zeros cannot be undone
  assign blank_err = (cmd_i == Write) && (|(mem_q[addr_i] & ~wdata_i));
  assign rsp_err   = blank_err ? MacroWriteBlankError : NoError;

  ////////////////////////////////////////
  // Fuse array
  ////////////////////////////////////////

  // Blank array after reset, programming ORs into the stored word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (gnt_o && (cmd_i == Write)) begin
      mem_q[addr_i] <= mem_q[addr_i] | wdata_i;
    end
  end

  ////////////////////////////////////////
  // Response pipeline
  ////////////////////////////////////////

  // Valid and error code travel together through the latency stages
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Latency; i++) begin
        vld_q[i] <= 1'b0;
        err_q[i] <= NoError;
      end
    end else begin
      vld_q[0] <= gnt_o;
      err_q[0] <= gnt_o ? rsp_err : NoError;
      for (int i = 1; i < Latency; i++) begin
        vld_q[i] <= vld_q[i-1];
        err_q[i] <= err_q[i-1];
      end
    end
  end

  // Last stage is the registered response
  assign rvalid_o = vld_q[Latency-1];
  assign err_o    = err_q[Latency-1];

endmodule

//--- hdl/otp_lci_top.sv
/*
  Life cycle interface wired to the OTP macro model.
  Only the life cycle controller side is visible at this level.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module otp_lci_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       lci_en_i,
  input  lc_tx_pkg::lc_tx_t          escalate_en_i,
  input  logic                       lc_req_i,
  input  logic [`LC_DATA_WIDTH-1:0]  lc_data_i,
  output logic                       lc_ack_o,
  output logic                       lc_err_o,
  output otp_macro_pkg::err_e        error_o,
  output logic                       fsm_err_o,
  output logic                       lci_prog_idle_o
);

  import otp_macro_pkg::*;

  // Macro port between the interface and the array
  logic                       otp_req;
  cmd_e                       otp_cmd;
  logic [`OTP_ADDR_WIDTH-1:0] otp_addr;
  logic [`OTP_WIDTH-1:0]      otp_wdata;
  logic                       otp_gnt;
  logic                       otp_rvalid;
  err_e                       otp_err;

  otp_lci u_lci (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .otp_req_o       (otp_req),
    .otp_cmd_o       (otp_cmd),
    .otp_addr_o      (otp_addr),
    .otp_wdata_o     (otp_wdata),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_err_i       (otp_err)
  );

  otp_macro_model u_macro (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (otp_req),
    .cmd_i    (otp_cmd),
    .addr_i   (otp_addr),
    .wdata_i  (otp_wdata),
    .gnt_o    (otp_gnt),
    .rvalid_o (otp_rvalid),
    .err_o    (otp_err)
  );

endmodule

//--- verification/otp_lci_sva.sv
/*
  Concurrent assertions on the life cycle interface FSM and macro port.
  Attached to every otp_lci instance through the bind below.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module otp_lci_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic [8:0]          state_i,
  input logic                lc_ack_i,
  input logic                otp_req_i,
  input otp_macro_pkg::cmd_e otp_cmd_i,
  input logic                otp_gnt_i,
  input logic                otp_rvalid_i
);

  import otp_macro_pkg::*;

  // Terminal state encoding of the interface FSM
  localparam logic [8:0] ErrorSt = 9'b011111101;

  // Exactly one response per grant, after the fixed latency
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_rvalid_i == $past(otp_gnt_i, `MACRO_LATENCY))
    else $error("rvalid does not match a grant");

  // No request is withdrawn before it is granted
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (otp_req_i && !otp_gnt_i) |=> otp_req_i)
    else $error("request dropped before grant");

  // This interface only programs
  req_is_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_i |-> (otp_cmd_i == Write))
    else $error("request with a read command");

  ack_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lc_ack_i && otp_req_i))
    else $error("acknowledge during a macro request");

  // Only reset leaves the terminal state
  error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == ErrorSt) |=> (state_i == ErrorSt))
    else $error("FSM left the error state");

endmodule

bind otp_lci otp_lci_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .state_i      (state_q),
  .lc_ack_i     (lc_ack_o),
  .otp_req_i    (otp_req_o),
  .otp_cmd_i    (otp_cmd_o),
  .otp_gnt_i    (otp_gnt_i),
  .otp_rvalid_i (otp_rvalid_i)
);

//--- verification/otp_lci_tb.sv
/*
  Directed testbench for the OTP life cycle interface and its macro model.
  Compile it with src.f. The run ends with a single pass or fail line.
*/
`timescale 1ns/10ps
`include "otp_cfg.svh"

module otp_lci_tb;

  import otp_macro_pkg::*;
  import lc_tx_pkg::*;

  localparam int DataWidth = `LC_DATA_WIDTH;
  // Request is seen one cycle after it is driven, then grant plus latency per word
  localparam int AckCycles = 1 + `LC_WORDS * (1 + `MACRO_LATENCY);
  localparam int Timeout   = 4 * AckCycles;
  localparam int QuietWin  = 40;

  logic                 clk;
  logic                 rst_n;
  logic                 lci_en;
  lc_tx_t               escalate_en;
  logic                 lc_req;
  logic [DataWidth-1:0] lc_data;
  logic                 lc_ack;
  logic                 lc_err;
  err_e                 err_code;
  logic                 fsm_err;
  logic                 prog_idle;

  integer               seed;
  // Expected fuse contents of the life cycle partition
  logic [DataWidth-1:0] fuse_img;
  logic [DataWidth-1:0] vec_a;

  otp_lci_top dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .lci_en_i        (lci_en),
    .escalate_en_i   (escalate_en),
    .lc_req_i        (lc_req),
    .lc_data_i       (lc_data),
    .lc_ack_o        (lc_ack),
    .lc_err_o        (lc_err),
    .error_o         (err_code),
    .fsm_err_o       (fsm_err),
    .lci_prog_idle_o (prog_idle)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Checking and failure handling
  ////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    stop_on_failure();
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Inputs change a little after the rising edge
  task automatic next_drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst_n       = 1'b0;
    lci_en      = 1'b0;
    lc_req      = 1'b0;
    escalate_en = LcTxOff;
    repeat (10) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    // Macro array comes out of reset blank
    fuse_img = '0;
  endtask

  function automatic logic [DataWidth-1:0] rand_vector();
    logic [DataWidth-1:0] v;
    v = '0;
    for (int i = 0; i < DataWidth / 32; i++) begin
      v = {v[DataWidth-33:0], 32'($random(seed))};
    end
    return v;
  endfunction

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (prog_idle !== 1'b1) begin
      if (n == Timeout) begin
        give_up({name, " idle"});
      end
      @(negedge clk);
      n++;
    end
  endtask

  // Checked on falling edges while the request stays up
  task automatic expect_no_ack(input string name);
    for (int i = 0; i < QuietWin; i++) begin
      @(negedge clk);
      check_eq(name, 0, 32'(lc_ack));
    end
  endtask

  // Drives one full transition request and checks it against the fuse image
  task automatic program_vector(input string name, input logic [DataWidth-1:0] vec);
    int   cycles;
    logic blank_hit;
    // A stored one that vec lacks cannot be written back to zero
    blank_hit = |(fuse_img & ~vec);
    next_drive_slot();
    lc_data = vec;
    lc_req  = 1'b1;
    cycles  = 0;
    while (lc_ack !== 1'b1) begin
      if (cycles == Timeout) begin
        give_up({name, " acknowledge"});
      end
      @(negedge clk);
      cycles++;
    end
    check_eq({name, " ack latency"}, AckCycles, cycles);
    check_eq({name, " lc_err"}, 32'(blank_hit), 32'(lc_err));
    next_drive_slot();
    lc_req   = 1'b0;
    // The array ORs every word in even when a word fails
    fuse_img = fuse_img | vec;
    @(negedge clk);
    check_eq({name, " ack width"}, 0, 32'(lc_ack));
    check_eq({name, " error code"},
             32'(blank_hit ? MacroWriteBlankError : NoError), 32'(err_code));
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_before_enable();
    next_drive_slot();
    lc_req = 1'b1;
    // Neither idle nor an acknowledge may show up while disabled
    for (int i = 0; i < QuietWin; i++) begin
      @(negedge clk);
      check_eq("ack before enable", 0, 32'(lc_ack));
      check_eq("idle before enable", 0, 32'(prog_idle));
    end
    next_drive_slot();
    lc_req = 1'b0;
    lci_en = 1'b1;
    wait_idle("enable");
  endtask

  task automatic test_clear_bit();
    logic [DataWidth-1:0] vec_b;
    // Drop the lowest programmed bit of the stored image
    vec_b = fuse_img & (fuse_img - DataWidth'(1));
    program_vector("clear one bit", vec_b);
    next_drive_slot();
    lc_req = 1'b1;
    expect_no_ack("request after blank error");
    next_drive_slot();
    lc_req = 1'b0;
  endtask

  task automatic test_escalation();
    apply_reset();
    next_drive_slot();
    lci_en = 1'b1;
    wait_idle("escalation setup");
    next_drive_slot();
    escalate_en = LcTxOn;
    @(negedge clk);
    check_eq("fsm_err on escalation", 1, 32'(fsm_err));
    next_drive_slot();
    escalate_en = LcTxOff;
    @(negedge clk);
    check_eq("error code on escalation", 32'(FsmStateError), 32'(err_code));
    check_eq("fsm_err after escalation", 0, 32'(fsm_err));
    next_drive_slot();
    lc_data = rand_vector();
    lc_req  = 1'b1;
    expect_no_ack("request after escalation");
    next_drive_slot();
    lc_req = 1'b0;
  endtask

  initial begin
    clk      = 1'b0;
    seed     = 23;
    lc_data  = '0;
    apply_reset();
    test_before_enable();
    vec_a = rand_vector();
    program_vector("program random", vec_a);
    program_vector("program superset", vec_a | rand_vector());
    test_clear_bit();
    test_escalation();
    $display("Test passed");
    $finish;
  end

endmodule

//--- src.f
+incdir+hdl
hdl/otp_macro_pkg.sv
hdl/lc_tx_pkg.sv
hdl/lci_word_count.sv
hdl/otp_lci.sv
hdl/otp_macro_model.sv
hdl/otp_lci_top.sv
verification/otp_lci_sva.sv
verification/otp_lci_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --timing --assert
TOP       = otp_lci_tb
LINT_TOP  = otp_lci_top
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

# Pass only if the simulation output holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
